/* common/vid_defs.svh */
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// ########################################
// Address map
// ########################################
`define VID_RAM_START      16'h0000
`define VID_SPR0_START     16'hA000
`define VID_SPR1_START     16'hA400
`define VID_TILEMAP_START  16'hC000
`define VID_FB_START       16'hE000
`define VID_IO_START       16'hF000

`define VID_SPR0_X         16'hFFE0
`define VID_SPR0_Y         16'hFFE1
`define VID_SPR1_X         16'hFFE2
`define VID_SPR1_Y         16'hFFE3
`define VID_SCALE_REG      16'hFFFC
`define VID_HSCROLL_REG    16'hFFFD
`define VID_VSCROLL_REG    16'hFFFE
`define VID_PS2_REG        16'hFFFF

// ########################################
// Region sizes and video geometry
// ########################################
`define VID_RAM_WORDS      32768
`define VID_SPR_WORDS      1024
`define VID_TILEMAP_WORDS  8192
`define VID_FB_WORDS       4096

`define VID_SPR_SIZE       32
`define VID_TILE_SIZE      8
`define VID_FB_ROW_TILES   128 // Two tile numbers share one framebuffer word.
`define VID_TRANSPARENT    16'hF000

`endif

/* common/vid_pkg.sv */
`default_nettype none

package vid_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [9:0]  coord_t;
    typedef logic [11:0] rgb_t;

    // One CPU write, broadcast to every block.
    typedef struct packed {
        logic      en;
        bus_addr_t addr;
        bus_data_t data;
    } cpu_wr_t;

    // Screen coordinate after scale and scroll.
    typedef struct packed {
        coord_t x;
        coord_t y;
    } view_coord_t;

    // Bottom-right corner of a sprite window.
    typedef struct packed {
        bus_data_t x;
        bus_data_t y;
    } sprite_pos_t;

    // Candidate pixel from one sprite layer.
    typedef struct packed {
        logic      valid;
        bus_data_t colour;
    } layer_pix_t;

endpackage

`default_nettype wire

/* design/cpu_mem.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vid_defs.svh"

module cpu_mem (
    input  wire                clk,
    input  wire                rst,
    input  wire vid_pkg::cpu_wr_t   wr,
    input  wire vid_pkg::bus_addr_t rd_addr,
    input  wire                ren,
    input  wire vid_pkg::bus_data_t fb_rdata,
    input  wire vid_pkg::bus_data_t tm_rdata,
    input  wire vid_pkg::bus_data_t reg_rdata,
    input  wire vid_pkg::bus_data_t ps2_data,
    output vid_pkg::bus_data_t rdata,
    output logic               ps2_ren
);

    import vid_pkg::*;

    bus_data_t ram [0:`VID_RAM_WORDS-1];

    bus_addr_t wr_off;
    bus_addr_t rd_off;
    logic      ram_wr;
    bus_addr_t rd_q;
    bus_data_t ram_q;
    bus_data_t sel_data;

    assign wr_off = wr.addr - `VID_RAM_START;
    assign rd_off = rd_addr - `VID_RAM_START;
    assign ram_wr = wr.en && (wr.addr < 16'(`VID_RAM_START + `VID_RAM_WORDS));

    // The keyboard sees the read in the cycle it is issued.
    assign ps2_ren = ren && (rd_addr == `VID_PS2_REG);

    // ########################################
    // Main RAM, first read stage
    // ########################################
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            ram[wr_off[14:0]] <= wr.data;
        end
        ram_q <= ram[rd_off[14:0]]; // Old word when read and write share an edge.
        rd_q  <= rd_addr;
    end

    // ########################################
    // Second read stage
    // ########################################
    always_comb begin
        if (rd_q < 16'(`VID_RAM_START + `VID_RAM_WORDS)) begin
            sel_data = ram_q;
        end else if (rd_q >= `VID_TILEMAP_START && rd_q < `VID_FB_START) begin
            sel_data = tm_rdata;
        end else if (rd_q >= `VID_FB_START && rd_q < `VID_IO_START) begin
            sel_data = fb_rdata;
        end else if (rd_q == `VID_SCALE_REG || rd_q == `VID_HSCROLL_REG ||
                     rd_q == `VID_VSCROLL_REG) begin
            sel_data = reg_rdata;
        end else if (rd_q == `VID_PS2_REG) begin
            sel_data = ps2_data; // Keyboard value live at this edge.
        end else begin
            sel_data = '0; // Sprite regions and unmapped IO read as zero.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= sel_data;
        end
    end

endmodule

`default_nettype wire

/* design/vid_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vid_mem_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire vid_pkg::bus_addr_t rd_addr,
    input  wire                     ren,
    output vid_pkg::bus_data_t      rdata,
    input  wire                     wen,
    input  wire vid_pkg::bus_addr_t wr_addr,
    input  wire vid_pkg::bus_data_t wr_data,
    output logic                    ps2_ren,
    input  wire vid_pkg::bus_data_t ps2_data,
    input  wire vid_pkg::coord_t    pixel_x,
    input  wire vid_pkg::coord_t    pixel_y,
    output vid_pkg::rgb_t           pixel
);

    import vid_pkg::*;

    cpu_wr_t     wr;
    bus_data_t   fb_rdata;
    bus_data_t   tm_rdata;
    bus_data_t   reg_rdata;
    bus_data_t   bg_word;
    view_coord_t view;
    sprite_pos_t spr0_pos;
    sprite_pos_t spr1_pos;
    layer_pix_t  spr0_pix;
    layer_pix_t  spr1_pix;

    assign wr = '{en: wen, addr: wr_addr, data: wr_data}; // Each block decodes its own region.

    // ########################################
    // CPU side
    // ########################################
    cpu_mem cpu_mem_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .ren       (ren),
        .fb_rdata  (fb_rdata),
        .tm_rdata  (tm_rdata),
        .reg_rdata (reg_rdata),
        .ps2_data  (ps2_data),
        .rdata     (rdata),
        .ps2_ren   (ps2_ren)
    );

    video_regs video_regs_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .reg_rdata (reg_rdata),
        .view      (view),
        .spr0_pos  (spr0_pos),
        .spr1_pos  (spr1_pos)
    );

    // ########################################
    // Video side
    // ########################################
    background_fetch background_fetch_i (
        .clk      (clk),
        .wr       (wr),
        .rd_addr  (rd_addr),
        .view     (view),
        .fb_rdata (fb_rdata),
        .tm_rdata (tm_rdata),
        .bg_word  (bg_word)
    );

    sprite_fetch sprite_fetch_i (
        .clk      (clk),
        .wr       (wr),
        .view     (view),
        .spr0_pos (spr0_pos),
        .spr1_pos (spr1_pos),
        .spr0_pix (spr0_pix),
        .spr1_pix (spr1_pix)
    );

    pixel_compositor pixel_compositor_i (
        .clk      (clk),
        .rst      (rst),
        .spr0_pix (spr0_pix),
        .spr1_pix (spr1_pix),
        .bg_word  (bg_word),
        .pixel    (pixel)
    );

endmodule

`default_nettype wire

/* design/video_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vid_defs.svh"

module video_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire vid_pkg::cpu_wr_t   wr,
    input  wire vid_pkg::bus_addr_t rd_addr,
    input  wire vid_pkg::coord_t    pixel_x,
    input  wire vid_pkg::coord_t    pixel_y,
    output vid_pkg::bus_data_t      reg_rdata,
    output vid_pkg::view_coord_t    view,
    output vid_pkg::sprite_pos_t    spr0_pos,
    output vid_pkg::sprite_pos_t    spr1_pos
);

    import vid_pkg::*;

    bus_data_t scale;
    bus_data_t hscroll;
    bus_data_t vscroll;
    bus_data_t x_scaled;
    bus_data_t y_scaled;
    bus_data_t x_view;
    bus_data_t y_view;

    always_ff @(posedge clk) begin
        if (rst) begin
            scale    <= '0;
            hscroll  <= '0;
            vscroll  <= '0;
            spr0_pos <= '0; // Position 0 keeps the sprite off screen.
            spr1_pos <= '0;
        end else if (wr.en) begin
            case (wr.addr)
                `VID_SPR0_X:      spr0_pos.x <= wr.data;
                `VID_SPR0_Y:      spr0_pos.y <= wr.data;
                `VID_SPR1_X:      spr1_pos.x <= wr.data;
                `VID_SPR1_Y:      spr1_pos.y <= wr.data;
                `VID_SCALE_REG:   scale      <= wr.data;
                `VID_HSCROLL_REG: hscroll    <= wr.data;
                `VID_VSCROLL_REG: vscroll    <= wr.data;
                default: ;
            endcase
        end
    end

    // Sprite positions are write-only from the CPU side.
    always_ff @(posedge clk) begin
        case (rd_addr)
            `VID_SCALE_REG:   reg_rdata <= scale;
            `VID_HSCROLL_REG: reg_rdata <= hscroll;
            `VID_VSCROLL_REG: reg_rdata <= vscroll;
            default:          reg_rdata <= '0;
        endcase
    end

    // ########################################
    // View coordinate transform
    // ########################################
    assign x_scaled = {6'b0, pixel_x} >> scale;
    assign y_scaled = {6'b0, pixel_y} >> scale;
    assign x_view   = x_scaled + hscroll;
    assign y_view   = y_scaled + vscroll;

    assign view = '{x: x_view[9:0], y: y_view[9:0]}; // Wraps at 1024.

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
+incdir+tb
common/vid_pkg.sv
design/cpu_mem.sv
design/video_regs.sv
video/background_fetch.sv
video/sprite_fetch.sv
video/pixel_compositor.sv
design/vid_mem_top.sv
tb/tb_vid_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_vid_mem -f filelist.f

# The simulator exit code is not checked here; the log decides.
./obj_dir/Vtb_vid_mem 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

/* tb/vid_mem_tests.svh */
// ########################################
// Expected values from the memory map rules
// ########################################
function automatic bus_data_t tile_pattern(input int idx);
    return bus_data_t'(idx * 40503 + 4660); // Odd multiplier keeps every word distinct.
endfunction

function automatic bus_data_t sprite_pattern(input int s, input int idx);
    if (((idx >> (2 * s + 1)) & 3) == 0) begin
        return `VID_TRANSPARENT;
    end else begin
        return {4'h0, 12'(idx * (3 + 2 * s) + 16'h111 * (s + 1))};
    end
endfunction

function automatic coord_t view_x(input coord_t px);
    return coord_t'((16'(px) >> scale_model) + hscroll_model);
endfunction

function automatic coord_t view_y(input coord_t py);
    return coord_t'((16'(py) >> scale_model) + vscroll_model);
endfunction

function automatic bus_data_t bg_expect(input coord_t vx, input coord_t vy);
    int        slot;
    int        tile;
    int        idx;
    bus_data_t fbw;
    slot = int'(vx) / `VID_TILE_SIZE + (int'(vy) / `VID_TILE_SIZE) * `VID_FB_ROW_TILES;
    fbw  = fb_model[(slot / 2) % `VID_FB_WORDS];
    tile = (slot % 2 == 1) ? int'(fbw[15:8]) : int'(fbw[7:0]);
    idx  = tile * 64 + (int'(vy) % 8) * 8 + int'(vx) % 8;
    return tm_model[idx % `VID_TILEMAP_WORDS];
endfunction

function automatic logic sprite_hit(input int s, input coord_t vx, input coord_t vy);
    bus_data_t px;
    bus_data_t py;
    bus_data_t x_lo;
    bus_data_t y_lo;
    px   = pos_model[2 * s];
    py   = pos_model[2 * s + 1];
    x_lo = px - 16'd32;
    y_lo = py - 16'd32;
    return (x_lo < 16'(vx)) && (16'(vx) <= px) && (y_lo < 16'(vy)) && (16'(vy) <= py);
endfunction

function automatic rgb_t pixel_expect(input coord_t px, input coord_t py);
    coord_t    vx;
    coord_t    vy;
    int        idx;
    bus_data_t word;
    vx   = view_x(px);
    vy   = view_y(py);
    idx  = (int'(vy) % 32) * 32 + int'(vx) % 32;
    word = bg_expect(vx, vy);
    for (int s = 0; s < 2; s++) begin
        if (sprite_hit(s, vx, vy) && spr_model[s][idx][15:12] == 4'h0) begin
            word = spr_model[s][idx]; // Sprite 1 is tested last and wins.
        end
    end
    return word[11:0];
endfunction

task automatic queue_read(input bus_addr_t addr, input bus_data_t expected);
    addr_q.push_back(addr);
    exp_q.push_back(expected);
endtask

task automatic queue_pixel(input int px, input int py);
    pix_x_q.push_back(coord_t'(px));
    pix_y_q.push_back(coord_t'(py));
    pix_exp_q.push_back(pixel_expect(coord_t'(px), coord_t'(py)));
endtask

// ########################################
// Directed tests
// ########################################
task automatic check_after_reset();
    check_equal(rdata, 16'h0000, "rdata after reset");
    check_equal({4'h0, pixel}, 16'h0000, "pixel after reset");
endtask

task automatic test_ram();
    bus_addr_t addrs [0:7];
    addrs = '{16'h0000, 16'h0001, 16'h0123, 16'h1F00, 16'h4000, 16'h5A5A, 16'h7FFE, 16'h7FFF};
    for (int i = 0; i < 8; i++) begin
        cpu_write(addrs[i], {addrs[i][7:0], addrs[i][15:8]} ^ 16'h3C3C);
        queue_read(addrs[i], ram_model[addrs[i][14:0]]);
        run_reads();
    end
    for (int i = 7; i >= 0; i--) begin
        queue_read(addrs[i], ram_model[addrs[i][14:0]]); // Back to back, reverse order.
    end
    run_reads();
endtask

task automatic test_regs_and_keyboard();
    cpu_write(`VID_SCALE_REG, 16'h0003);
    cpu_write(`VID_HSCROLL_REG, 16'h1234);
    cpu_write(`VID_VSCROLL_REG, 16'hABCD);
    cpu_write(`VID_SPR0_X, 16'h0055);
    queue_read(`VID_SCALE_REG, 16'h0003);
    queue_read(`VID_HSCROLL_REG, 16'h1234);
    queue_read(`VID_VSCROLL_REG, 16'hABCD);
    queue_read(`VID_SPR0_X, 16'h0000);
    queue_read(`VID_IO_START, 16'h0000);
    queue_read(`VID_SPR0_START, 16'h0000);
    run_reads();

    ps2_data = 16'h5A3C;
    ren      = 1'b1;
    rd_addr  = `VID_PS2_REG;
    wait_ps2_ren(15);
    @(negedge clk);
    ren      = 1'b0;
    ps2_data = 16'hC3A5; // The keyboard word is taken at the second edge of the read.
    #1;
    check_equal({15'h0, ps2_ren}, 16'h0000, "ps2_ren with ren low");
    @(negedge clk);
    check_equal(rdata, 16'hC3A5, "keyboard read data");
    rd_addr = '0;

    cpu_write(`VID_SCALE_REG, 16'h0000);
    cpu_write(`VID_HSCROLL_REG, 16'h0000);
    cpu_write(`VID_VSCROLL_REG, 16'h0000);
    cpu_write(`VID_SPR0_X, 16'h0000);
endtask

task automatic test_background();
    int idx;
    for (int t = 0; t < 2; t++) begin
        for (int i = 0; i < 64; i++) begin
            idx = (t == 0 ? 5 : 9) * 64 + i;
            cpu_write(bus_addr_t'(`VID_TILEMAP_START + idx), tile_pattern(idx));
        end
    end
    // Tiles 5 and 9 alternate in both byte halves over a 10 by 9 tile corner.
    for (int r = 0; r < 9; r++) begin
        for (int w = 0; w < 5; w++) begin
            cpu_write(bus_addr_t'(`VID_FB_START + r * (`VID_FB_ROW_TILES / 2) + w),
                      ((r + w) % 2 == 0) ? 16'h0905 : 16'h0509);
        end
    end
    queue_read(bus_addr_t'(`VID_FB_START + 65), fb_model[65]);
    queue_read(bus_addr_t'(`VID_TILEMAP_START + 330), tm_model[330]);
    queue_read(bus_addr_t'(`VID_TILEMAP_START + 639), tm_model[639]);
    run_reads();
    for (int y = 0; y < 72; y += 3) begin
        for (int x = 0; x < 80; x += 3) begin
            queue_pixel(x, y);
        end
    end
    run_pixels();
endtask

task automatic test_scale_scroll();
    cpu_write(`VID_SCALE_REG, 16'h0001);
    cpu_write(`VID_HSCROLL_REG, 16'h0010);
    cpu_write(`VID_VSCROLL_REG, 16'h0008);
    for (int py = 0; py < 64; py += 5) begin
        for (int px = 0; px < 64; px += 3) begin
            queue_pixel(px, py);
        end
    end
    run_pixels();
    cpu_write(`VID_SCALE_REG, 16'h0002);
    cpu_write(`VID_HSCROLL_REG, 16'h0000);
    cpu_write(`VID_VSCROLL_REG, 16'h0004);
    for (int py = 0; py < 256; py += 9) begin
        for (int px = 0; px < 256; px += 7) begin
            queue_pixel(px, py);
        end
    end
    run_pixels();
    cpu_write(`VID_SCALE_REG, 16'h0000);
    cpu_write(`VID_VSCROLL_REG, 16'h0000);
endtask

task automatic test_sprites();
    for (int i = 0; i < `VID_SPR_WORDS; i++) begin
        cpu_write(bus_addr_t'(`VID_SPR0_START + i), sprite_pattern(0, i));
        if (sprite_pattern(1, i) != `VID_TRANSPARENT) begin
            cpu_write(bus_addr_t'(`VID_SPR1_START + i), sprite_pattern(1, i));
        end
    end
    cpu_write(`VID_SPR0_X, 16'd47);
    cpu_write(`VID_SPR0_Y, 16'd47);
    cpu_write(`VID_SPR1_X, 16'd63);
    cpu_write(`VID_SPR1_Y, 16'd55);
    queue_read(bus_addr_t'(`VID_SPR1_START + 40), 16'h0000);
    queue_read(`VID_SPR1_Y, 16'h0000);
    run_reads();
    for (int y = 0; y < 72; y += 3) begin
        for (int x = 0; x < 80; x += 3) begin
            queue_pixel(x, y);
        end
    end
    run_pixels();

    cpu_write(`VID_SPR1_X, 16'd0); // Sprite 1 fully at 0, sprite 0 only in x.
    cpu_write(`VID_SPR1_Y, 16'd0);
    cpu_write(`VID_SPR0_X, 16'd0);
    for (int y = 0; y < 72; y += 4) begin
        for (int x = 0; x < 80; x += 4) begin
            queue_pixel(x, y);
        end
    end
    run_pixels();
endtask

task automatic test_random();
    logic [31:0] r;
    bus_addr_t   a;
    bus_addr_t   written [$];
    for (int i = 0; i < 32; i++) begin
        r = $random(seed);
        a = r[20] ? (`VID_FB_START | bus_addr_t'(r[11:0])) : bus_addr_t'(r[14:0]);
        cpu_write(a, bus_data_t'($random(seed)));
        written.push_back(a);
    end
    foreach (written[i]) begin
        if (written[i] >= `VID_FB_START) begin
            queue_read(written[i], fb_model[written[i][11:0]]);
        end else begin
            queue_read(written[i], ram_model[written[i][14:0]]);
        end
    end
    run_reads();
endtask

/* tb/tb_vid_mem.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vid_defs.svh"

module tb_vid_mem;

    import vid_pkg::*;

    logic      clk;
    logic      rst;
    bus_addr_t rd_addr;
    logic      ren;
    bus_data_t rdata;
    logic      wen;
    bus_addr_t wr_addr;
    bus_data_t wr_data;
    logic      ps2_ren;
    bus_data_t ps2_data;
    coord_t    pixel_x;
    coord_t    pixel_y;
    rgb_t      pixel;

    // Reference copies of everything the CPU has written.
    bus_data_t ram_model [0:`VID_RAM_WORDS-1];
    bus_data_t fb_model  [0:`VID_FB_WORDS-1];
    bus_data_t tm_model  [0:`VID_TILEMAP_WORDS-1];
    bus_data_t spr_model [0:1][0:`VID_SPR_WORDS-1];
    bus_data_t pos_model [0:3]; // Sprite 0 x, sprite 0 y, sprite 1 x, sprite 1 y.
    bus_data_t scale_model;
    bus_data_t hscroll_model;
    bus_data_t vscroll_model;

    bus_addr_t addr_q [$];
    bus_data_t exp_q [$];
    coord_t    pix_x_q [$];
    coord_t    pix_y_q [$];
    rgb_t      pix_exp_q [$];

    integer seed;

    vid_mem_top vid_mem_top_i (
        .clk      (clk),
        .rst      (rst),
        .rd_addr  (rd_addr),
        .ren      (ren),
        .rdata    (rdata),
        .wen      (wen),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .ps2_ren  (ps2_ren),
        .ps2_data (ps2_data),
        .pixel_x  (pixel_x),
        .pixel_y  (pixel_y),
        .pixel    (pixel)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s: got %h, expected %h", $time, what, actual,
                     expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch");
        end
    endtask

    // ########################################
    // Waits, bus access and stream runners
    // ########################################
    task automatic step_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_ps2_ren(input int limit_ns);
        int t;
        t = 0;
        while (ps2_ren !== 1'b1 && t < limit_ns) begin
            #1;
            t++;
        end
        if (ps2_ren !== 1'b1) begin
            $display("Timeout: ps2_ren stayed low during a keyboard read at %0d ns", $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Keyboard strobe missing");
        end
    endtask

    task automatic cpu_write(input bus_addr_t addr, input bus_data_t data);
        wen     = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wen = 1'b0;
        if (addr < 16'(`VID_RAM_WORDS)) begin
            ram_model[addr[14:0]] = data;
        end else if (bus_addr_t'(addr - `VID_SPR0_START) < 16'(`VID_SPR_WORDS)) begin
            spr_model[0][addr[9:0]] = data;
        end else if (bus_addr_t'(addr - `VID_SPR1_START) < 16'(`VID_SPR_WORDS)) begin
            spr_model[1][addr[9:0]] = data;
        end else if (addr >= `VID_TILEMAP_START && addr < `VID_FB_START) begin
            tm_model[addr[12:0]] = data;
        end else if (addr >= `VID_FB_START && addr < `VID_IO_START) begin
            fb_model[addr[11:0]] = data;
        end else if (addr >= `VID_SPR0_X && addr <= `VID_SPR1_Y) begin
            pos_model[addr[1:0]] = data;
        end else if (addr == `VID_SCALE_REG) begin
            scale_model = data;
        end else if (addr == `VID_HSCROLL_REG) begin
            hscroll_model = data;
        end else if (addr == `VID_VSCROLL_REG) begin
            vscroll_model = data;
        end
    endtask

    // One address per cycle, each result checked two cycles after its address.
    task automatic run_reads();
        int n;
        n = addr_q.size();
        for (int i = 0; i <= n; i++) begin
            if (i < n) begin
                ren     = 1'b1;
                rd_addr = addr_q[i];
            end else begin
                ren = 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_equal(rdata, exp_q[i-1], $sformatf("read of %h", addr_q[i-1]));
            end
        end
        addr_q.delete();
        exp_q.delete();
    endtask

    task automatic run_pixels();
        int n;
        n = pix_x_q.size();
        for (int i = 0; i <= n; i++) begin
            if (i < n) begin
                pixel_x = pix_x_q[i];
                pixel_y = pix_y_q[i];
            end
            @(negedge clk);
            if (i > 0) begin
                check_equal({4'h0, pixel}, {4'h0, pix_exp_q[i-1]},
                            $sformatf("pixel at (%0d,%0d)", pix_x_q[i-1], pix_y_q[i-1]));
            end
        end
        pix_x_q.delete();
        pix_y_q.delete();
        pix_exp_q.delete();
    endtask

    `include "vid_mem_tests.svh"

    // ########################################
    // Test sequence
    // ########################################
    initial begin
        seed     = 7;
        rst      = 1'b1;
        ren      = 1'b0;
        rd_addr  = '0;
        wen      = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        ps2_data = '0;
        pixel_x  = '0;
        pixel_y  = '0;
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < `VID_SPR_WORDS; i++) begin
                spr_model[s][i] = `VID_TRANSPARENT;
            end
        end
        for (int i = 0; i < 4; i++) begin
            pos_model[i] = '0;
        end
        scale_model   = '0;
        hscroll_model = '0;
        vscroll_model = '0;

        step_cycles(8);
        rst = 1'b0;
        check_after_reset();

        test_ram();
        test_regs_and_keyboard();
        test_background();
        test_scale_scroll();
        test_sprites();
        test_random();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* video/background_fetch.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vid_defs.svh"

module background_fetch (
    input  wire                      clk,
    input  wire vid_pkg::cpu_wr_t    wr,
    input  wire vid_pkg::bus_addr_t  rd_addr,
    input  wire vid_pkg::view_coord_t view,
    output vid_pkg::bus_data_t       fb_rdata,
    output vid_pkg::bus_data_t       tm_rdata,
    output vid_pkg::bus_data_t       bg_word
);

    import vid_pkg::*;

    bus_data_t fb_mem [0:`VID_FB_WORDS-1];
    bus_data_t tm_mem [0:`VID_TILEMAP_WORDS-1];

    bus_addr_t   fb_wr_off;
    bus_addr_t   tm_wr_off;
    bus_addr_t   fb_rd_off;
    bus_addr_t   tm_rd_off;
    logic        fb_wr;
    logic        tm_wr;
    logic [12:0] slot;
    bus_data_t   fb_word_q;
    logic        odd_q;
    view_coord_t view_q;
    logic [7:0]  tile;
    logic [12:0] pat_idx;

    assign fb_wr_off = wr.addr - `VID_FB_START;
    assign tm_wr_off = wr.addr - `VID_TILEMAP_START;
    assign fb_rd_off = rd_addr - `VID_FB_START;
    assign tm_rd_off = rd_addr - `VID_TILEMAP_START;

    assign fb_wr = wr.en && wr.addr >= `VID_FB_START && wr.addr < `VID_IO_START;
    assign tm_wr = wr.en && wr.addr >= `VID_TILEMAP_START && wr.addr < `VID_FB_START;

    // Tile slot on the screen, truncated to the framebuffer depth.
    assign slot = 13'(view.x / `VID_TILE_SIZE) +
                  13'(view.y / `VID_TILE_SIZE) * 13'(`VID_FB_ROW_TILES);

    always_ff @(posedge clk) begin
        if (fb_wr) begin
            fb_mem[fb_wr_off[11:0]] <= wr.data;
        end
        if (tm_wr) begin
            tm_mem[tm_wr_off[12:0]] <= wr.data;
        end
        fb_rdata <= fb_mem[fb_rd_off[11:0]];
        tm_rdata <= tm_mem[tm_rd_off[12:0]];

        fb_word_q <= fb_mem[slot[12:1]];
        odd_q     <= slot[0]; // Odd slots live in the high byte.
        view_q    <= view;
    end

    // ########################################
    // Tile pattern lookup
    // ########################################
    assign tile = odd_q ? fb_word_q[15:8] : fb_word_q[7:0];

    assign pat_idx = 13'(tile) * 13'(`VID_TILE_SIZE * `VID_TILE_SIZE) +
                     13'(view_q.y % `VID_TILE_SIZE) * 13'(`VID_TILE_SIZE) +
                     13'(view_q.x % `VID_TILE_SIZE);

    assign bg_word = tm_mem[pat_idx];

endmodule

`default_nettype wire

/* video/pixel_compositor.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_compositor (
    input  wire                      clk,
    input  wire                      rst,
    input  wire vid_pkg::layer_pix_t spr0_pix,
    input  wire vid_pkg::layer_pix_t spr1_pix,
    input  wire vid_pkg::bus_data_t  bg_word,
    output vid_pkg::rgb_t            pixel
);

    import vid_pkg::*;

    bus_data_t chosen;

    // Sprite 1 sits on top, the background at the bottom.
    always_comb begin
        if (spr1_pix.valid) begin
            chosen = spr1_pix.colour;
        end else if (spr0_pix.valid) begin
            chosen = spr0_pix.colour;
        end else begin
            chosen = bg_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pixel <= '0;
        end else begin
            pixel <= chosen[11:0]; // Colour sits in the low 12 bits.
        end
    end

endmodule

`default_nettype wire

/* video/sprite_fetch.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vid_defs.svh"

module sprite_fetch (
    input  wire                       clk,
    input  wire vid_pkg::cpu_wr_t     wr,
    input  wire vid_pkg::view_coord_t view,
    input  wire vid_pkg::sprite_pos_t spr0_pos,
    input  wire vid_pkg::sprite_pos_t spr1_pos,
    output vid_pkg::layer_pix_t       spr0_pix,
    output vid_pkg::layer_pix_t       spr1_pix
);

    import vid_pkg::*;

    // Both images start fully transparent.
    bus_data_t spr_mem [0:1][0:`VID_SPR_WORDS-1] = '{default: `VID_TRANSPARENT};

    sprite_pos_t pos [0:1];
    bus_addr_t   wr_off [0:1];
    logic [1:0]  wr_sel;
    bus_data_t   vx;
    bus_data_t   vy;
    logic [1:0]  hit;
    logic [9:0]  spr_addr;
    logic [1:0]  hit_q;
    bus_data_t   word_q [0:1];

    assign pos[0] = spr0_pos;
    assign pos[1] = spr1_pos;

    assign wr_off[0] = wr.addr - `VID_SPR0_START;
    assign wr_off[1] = wr.addr - `VID_SPR1_START;
    assign wr_sel[0] = wr.en && (wr_off[0] < 16'(`VID_SPR_WORDS));
    assign wr_sel[1] = wr.en && (wr_off[1] < 16'(`VID_SPR_WORDS));

    assign vx = 16'(view.x);
    assign vy = 16'(view.y);

    // Window is the 32 pixels up to and including the corner.
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i] = (pos[i].x - 16'(`VID_SPR_SIZE) < vx) && (vx <= pos[i].x) &&
                     (pos[i].y - 16'(`VID_SPR_SIZE) < vy) && (vy <= pos[i].y);
        end
    end

    assign spr_addr = 10'(view.y % `VID_SPR_SIZE) * 10'(`VID_SPR_SIZE) +
                      10'(view.x % `VID_SPR_SIZE);

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (wr_sel[i]) begin
                spr_mem[i][wr_off[i][9:0]] <= wr.data;
            end
            hit_q[i]  <= hit[i];
            word_q[i] <= spr_mem[i][spr_addr];
        end
    end

    // Top nibble clear marks an opaque word.
    assign spr0_pix = '{valid: hit_q[0] && (word_q[0][15:12] == 4'h0), colour: word_q[0]};
    assign spr1_pix = '{valid: hit_q[1] && (word_q[1][15:12] == 4'h0), colour: word_q[1]};

endmodule

`default_nettype wire
